//--- joint_histogram_input.txt
# Commands: S ci ni rd gives one sample, R n gives n random samples, D runs a dump
# Lines that start with # are skipped
D
S 0 3 4
S 0 3 4
S 0 3 4
S 1 9 9
S 0 0 0
S 1 9 9
S 0 0 0
S 1 2 7
S 1 2 7
S 1 15 15
S 0 12 3
S 0 3 4
D
R 64
S 1 5 5
S 1 5 5
S 1 5 5
R 128
D
R 40
S 0 9 12
S 1 10 0
D

//--- joint_histogram.f
jh_cfg_pkg.sv
jh_ctrl_pkg.sv
jh_bin_address.sv
jh_sweep_counter.sv
jh_bin_memory.sv
jh_ctrl_fsm.sv
joint_histogram_top.sv
tb_joint_histogram.sv

//--- Bender.yml
package:
  name: joint_histogram

sources:
  - files:
      - jh_cfg_pkg.sv
      - jh_ctrl_pkg.sv
      - jh_bin_address.sv
      - jh_sweep_counter.sv
      - jh_bin_memory.sv
      - jh_ctrl_fsm.sv
      - joint_histogram_top.sv
  - target: test
    files:
      - tb_joint_histogram.sv

//--- tb_joint_histogram.sv
module tb_joint_histogram import jh_cfg_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic               clk;
	logic               rst_n;
	logic               sample_valid_i;
	logic [CI_W-1:0]    ci_i;
	logic [CODE_W-1:0]  ni_i;
	logic [CODE_W-1:0]  rd_i;
	logic               count_ready_o;
	logic               dump_req_i;
	logic               dump_ack_o;
	logic               bin_valid_o;
	logic [BIN_AW-1:0]  bin_index_o;
	logic [COUNT_W-1:0] bin_count_o;

	int unsigned model [NUM_BINS];
	byte         cmd_kind [$];
	int          cmd_a [$];
	int          cmd_b [$];
	int          cmd_c [$];
	int          total_samples = 0;
	int          total_dumps = 0;
	int          limit_cycles = 0;
	int          mismatch_errors = 0;
	int          protocol_errors = 0;
	int          timeout_errors = 0;
	logic [31:0] rng = 32'd93;

	joint_histogram_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Mostly legal codes with about one in eight landing in 10..15
	function automatic int pick_code(input logic [7:0] r);
		if (r[7:5] == 3'b000)
			return 10 + (r[4:0] % 6);
		return r % 10;
	endfunction

	task automatic finish_run;
		$display("Errors: %0d mismatch, %0d protocol, %0d timeout",
			mismatch_errors, protocol_errors, timeout_errors);
		if (mismatch_errors + protocol_errors + timeout_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	task automatic read_commands;
		int    fd;
		int    code;
		int    a;
		int    b;
		int    c;
		string tok;
		string rest;
		fd = $fopen("joint_histogram_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file joint_histogram_input.txt");
			protocol_errors++;
			return;
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			a = 0;
			b = 0;
			c = 0;
			if (tok.getc(0) == "#") begin
				void'($fgets(rest, fd)); // Comment line
				continue;
			end
			if (tok == "S") begin
				code = $fscanf(fd, "%d %d %d", a, b, c);
				if (code != 3) begin
					$display("A sample line in the stimulus file lacks one of its three fields");
					protocol_errors++;
				end
				total_samples++;
			end else if (tok == "R") begin
				code = $fscanf(fd, "%d", a);
				if (code != 1) begin
					$display("A random burst line in the stimulus file lacks its length");
					protocol_errors++;
				end
				total_samples += a;
			end else if (tok == "D") begin
				total_dumps++;
			end else begin
				$display("Unknown command %s in the stimulus file", tok);
				protocol_errors++;
				continue;
			end
			cmd_kind.push_back(tok.getc(0));
			cmd_a.push_back(a);
			cmd_b.push_back(b);
			cmd_c.push_back(c);
		end
		$fclose(fd);
	endtask

	// Called on a falling edge and returns on the falling edge after acceptance
	task automatic apply_sample(input int ci, input int ni, input int rd);
		int bin;
		sample_valid_i = 1'b1;
		ci_i = CI_W'(ci);
		ni_i = CODE_W'(ni);
		rd_i = CODE_W'(rd);
		while (!count_ready_o)
			@(negedge clk);
		bin = ci * CI_WEIGHT + ni * NI_WEIGHT + rd;
		if (bin < NUM_BINS)
			model[bin]++;
		@(negedge clk);
		sample_valid_i = 1'b0;
	endtask

	task automatic run_dump;
		int   nvalid;
		int   nclear;
		logic ended;
		logic prev_valid;
		nvalid = 0;
		nclear = 0;
		ended = 1'b0;
		prev_valid = 1'b0;
		dump_req_i = 1'b1;
		@(negedge clk);
		while (!dump_ack_o) begin
			if (count_ready_o) begin
				$display("count_ready_o is high while a dump is running");
				protocol_errors++;
			end
			if (bin_valid_o) begin
				if (ended) begin
					$display("bin_valid_o rose again after the dump stream ended");
					protocol_errors++;
				end
				if (nvalid < NUM_BINS) begin
					if (bin_index_o !== BIN_AW'(nvalid)) begin
						$display("Mismatch bin_index_o: got 0x%h, expected 0x%h",
							bin_index_o, BIN_AW'(nvalid));
						mismatch_errors++;
					end else if (bin_count_o !== model[nvalid]) begin
						$display("Mismatch bin_count_o[%0d]: got 0x%h, expected 0x%h",
							nvalid, bin_count_o, model[nvalid]);
						mismatch_errors++;
					end
				end
				nvalid++;
			end else if (nvalid > 0) begin
				ended = 1'b1;
			end
			prev_valid = bin_valid_o;
			@(negedge clk);
		end
		if (nvalid != NUM_BINS || !prev_valid) begin
			$display("dump_ack_o rose after %0d bins instead of right after bin %0d",
				nvalid, NUM_BINS - 1);
			protocol_errors++;
		end
		repeat (2) begin
			@(negedge clk);
			if (!dump_ack_o || count_ready_o) begin
				$display("dump_ack_o fell or count_ready_o rose while dump_req_i was high");
				protocol_errors++;
			end
		end
		dump_req_i = 1'b0;
		@(negedge clk);
		if (dump_ack_o) begin
			$display("dump_ack_o is still high one cycle after dump_req_i dropped");
			protocol_errors++;
		end
		while (!count_ready_o) begin
			nclear++;
			@(negedge clk);
		end
		if (nclear != NUM_BINS) begin
			$display("Clear sweep after the dump took %0d cycles instead of %0d",
				nclear, NUM_BINS);
			protocol_errors++;
		end
		foreach (model[i])
			model[i] = 0; // Table was cleared behind the dump
	endtask

	// ======================================================================
	// Main sequence and watchdog
	// ======================================================================

	initial begin
		int nclear;
		rst_n = 1'b0;
		sample_valid_i = 1'b0;
		ci_i = '0;
		ni_i = '0;
		rd_i = '0;
		dump_req_i = 1'b0;
		nclear = 0;
		foreach (model[i])
			model[i] = 0;
		read_commands();
		limit_cycles = total_samples + 450 * total_dumps + 300;
		repeat (4) begin
			@(negedge clk);
			if (count_ready_o || dump_ack_o || bin_valid_o) begin
				$display("An output handshake signal is high during reset");
				protocol_errors++;
			end
		end
		rst_n = 1'b1;
		while (!count_ready_o) begin
			nclear++;
			@(negedge clk);
		end
		if (nclear != NUM_BINS) begin
			$display("Clear sweep after reset took %0d cycles instead of %0d", nclear, NUM_BINS);
			protocol_errors++;
		end
		foreach (cmd_kind[k]) begin
			case (cmd_kind[k])
				"S": apply_sample(cmd_a[k], cmd_b[k], cmd_c[k]);
				"R": repeat (cmd_a[k]) begin
					rng = xorshift32(rng);
					apply_sample(rng[0], pick_code(rng[15:8]), pick_code(rng[23:16]));
				end
				default: run_dump();
			endcase
		end
		finish_run();
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
		timeout_errors++;
		finish_run();
	end

endmodule

//--- joint_histogram_top.sv
module joint_histogram_top import jh_cfg_pkg::*, jh_ctrl_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               sample_valid_i,
	input  logic [CI_W-1:0]    ci_i,
	input  logic [CODE_W-1:0]  ni_i,
	input  logic [CODE_W-1:0]  rd_i,
	output logic               count_ready_o,
	input  logic               dump_req_i,
	output logic               dump_ack_o,
	output logic               bin_valid_o,
	output logic [BIN_AW-1:0]  bin_index_o,
	output logic [COUNT_W-1:0] bin_count_o
);

	jh_op_e            op;
	logic              start;
	logic [BIN_AW-1:0] index;
	logic              last;
	logic              addr_valid;
	logic [BIN_AW-1:0] addr;

	jh_ctrl_fsm u_ctrl_fsm (
		.clk           (clk),
		.rst_n         (rst_n),
		.dump_req_i    (dump_req_i),
		.last_i        (last),
		.op_o          (op),
		.start_o       (start),
		.count_ready_o (count_ready_o),
		.dump_ack_o    (dump_ack_o)
	);

	jh_sweep_counter u_sweep_counter (
		.clk     (clk),
		.rst_n   (rst_n),
		.op_i    (op),
		.start_i (start),
		.index_o (index),
		.last_o  (last)
	);

	jh_bin_address u_bin_address (
		.clk            (clk),
		.rst_n          (rst_n),
		.sample_valid_i (sample_valid_i),
		.ci_i           (ci_i),
		.ni_i           (ni_i),
		.rd_i           (rd_i),
		.count_ready_i  (count_ready_o),
		.addr_valid_o   (addr_valid),
		.addr_o         (addr)
	);

	jh_bin_memory u_bin_memory (
		.clk          (clk),
		.rst_n        (rst_n),
		.op_i         (op),
		.index_i      (index),
		.addr_valid_i (addr_valid),
		.addr_i       (addr),
		.bin_valid_o  (bin_valid_o),
		.bin_index_o  (bin_index_o),
		.bin_count_o  (bin_count_o)
	);

endmodule

//--- jh_ctrl_fsm.sv
module jh_ctrl_fsm import jh_ctrl_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   dump_req_i,
	input  logic   last_i,
	output jh_op_e op_o,
	output logic   start_o,
	output logic   count_ready_o,
	output logic   dump_ack_o
);

	jh_state_e state_q;
	jh_state_e state_d;
	logic      ack_q;

	// ======================================================================
	// State sequencing
	// ======================================================================

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_CLEAR: if (last_i) state_d = ST_COUNT;
			ST_COUNT: if (dump_req_i) state_d = ST_DRAIN;
			ST_DRAIN: if (last_i) state_d = ST_DUMP;
			ST_DUMP:  if (last_i) state_d = ST_ACK;
			ST_ACK:   if (!dump_req_i) state_d = ST_CLEAR; // Host has seen the ack
			default:  state_d = ST_CLEAR;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_CLEAR; // Table content is unknown after reset
			ack_q <= 1'b0;
		end else begin
			state_q <= state_d;
			ack_q <= (state_q == ST_ACK) && dump_req_i;
		end
	end

	// ======================================================================
	// Outputs
	// ======================================================================

	always_comb begin
		case (state_q)
			ST_CLEAR: op_o = OP_CLEAR;
			ST_COUNT: op_o = OP_COUNT;
			ST_DRAIN: op_o = OP_DRAIN;
			ST_DUMP:  op_o = OP_DUMP;
			default:  op_o = OP_IDLE;
		endcase
	end

	// Counter restarts on the edge that enters a swept state
	assign start_o = (state_d != state_q) && (state_d inside {ST_CLEAR, ST_DRAIN, ST_DUMP});

	assign count_ready_o = (state_q == ST_COUNT);
	assign dump_ack_o = ack_q; // Rises one cycle after the last bin leaves the memory

endmodule

//--- jh_bin_memory.sv
module jh_bin_memory import jh_cfg_pkg::*, jh_ctrl_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  jh_op_e             op_i,
	input  logic [BIN_AW-1:0]  index_i,
	input  logic               addr_valid_i,
	input  logic [BIN_AW-1:0]  addr_i,
	output logic               bin_valid_o,
	output logic [BIN_AW-1:0]  bin_index_o,
	output logic [COUNT_W-1:0] bin_count_o
);

	logic [COUNT_W-1:0] table_q [NUM_BINS];

	logic               rmw_en;
	logic               take;
	logic               fwd;
	logic               pend_q;     // A read count waits to be written back
	logic [BIN_AW-1:0]  pend_addr_q;
	logic [COUNT_W-1:0] rd_count_q;

	// ======================================================================
	// Read-modify-write for counting
	// ======================================================================

	// Drain keeps the RMW running so samples already in flight land
	assign rmw_en = (op_i == OP_COUNT) || (op_i == OP_DRAIN);
	assign take = rmw_en && addr_valid_i && (addr_i < BIN_AW'(NUM_BINS));

	// The table still holds the old value while the previous write is pending
	assign fwd = pend_q && (pend_addr_q == addr_i);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pend_q <= 1'b0;
		else
			pend_q <= take;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			pend_addr_q <= addr_i;
			rd_count_q <= fwd ? rd_count_q + 1'b1 : table_q[addr_i];
		end
	end

	// Single write port, the clear sweep has priority
	always_ff @(posedge clk) begin
		if (op_i == OP_CLEAR)
			table_q[index_i] <= '0;
		else if (pend_q)
			table_q[pend_addr_q] <= rd_count_q + 1'b1;
	end

	// ======================================================================
	// Dump stream
	// ======================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			bin_valid_o <= 1'b0;
		else
			bin_valid_o <= (op_i == OP_DUMP);
	end

	always_ff @(posedge clk) begin
		if (op_i == OP_DUMP) begin
			bin_index_o <= index_i;
			bin_count_o <= table_q[index_i];
		end
	end

endmodule

//--- jh_sweep_counter.sv
module jh_sweep_counter import jh_cfg_pkg::*, jh_ctrl_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  jh_op_e            op_i,
	input  logic              start_i,
	output logic [BIN_AW-1:0] index_o,
	output logic              last_o
);

	logic [BIN_AW-1:0] cnt_q;
	logic [BIN_AW-1:0] last_idx;
	logic              sweeping;

	always_comb begin
		case (op_i)
			OP_CLEAR, OP_DUMP: last_idx = BIN_AW'(NUM_BINS - 1);
			OP_DRAIN:          last_idx = BIN_AW'(DRAIN_CYCLES - 1);
			default:           last_idx = '0;
		endcase
	end

	assign sweeping = op_i inside {OP_CLEAR, OP_DUMP, OP_DRAIN};
	assign last_o = sweeping && (cnt_q == last_idx);

	// Holds on the final step until the controller restarts it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cnt_q <= '0;
		else if (start_i)
			cnt_q <= '0;
		else if (sweeping && !last_o)
			cnt_q <= cnt_q + 1'b1;
	end

	assign index_o = cnt_q;

endmodule

//--- jh_bin_address.sv
module jh_bin_address import jh_cfg_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              sample_valid_i,
	input  logic [CI_W-1:0]   ci_i,
	input  logic [CODE_W-1:0] ni_i,
	input  logic [CODE_W-1:0] rd_i,
	input  logic              count_ready_i,
	output logic              addr_valid_o,
	output logic [BIN_AW-1:0] addr_o
);

	logic              s1_valid_q;
	logic [CI_W-1:0]   ci_q;
	logic [CODE_W-1:0] ni_q;
	logic [CODE_W-1:0] rd_q;
	logic [BIN_AW:0]   bin_sum; // One spare bit so large codes cannot wrap into a valid bin

	// Multiply by a constant weight as a sum of shifted copies
	function automatic logic [BIN_AW:0] scale(input logic [CODE_W-1:0] val,
			input int unsigned weight);
		logic [BIN_AW:0] acc;
		acc = '0;
		for (int b = 0; b <= BIN_AW; b++) begin
			if (weight[b])
				acc = acc + ((BIN_AW+1)'(val) << b);
		end
		return acc;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid_q <= 1'b0;
			addr_valid_o <= 1'b0;
		end else begin
			s1_valid_q <= sample_valid_i && count_ready_i;
			addr_valid_o <= s1_valid_q;
		end
	end

	always_ff @(posedge clk) begin
		if (sample_valid_i && count_ready_i) begin
			ci_q <= ci_i;
			ni_q <= ni_i;
			rd_q <= rd_i;
		end
	end

	assign bin_sum = scale(CODE_W'(ci_q), CI_WEIGHT) + scale(ni_q, NI_WEIGHT)
		+ (BIN_AW+1)'(rd_q);

	always_ff @(posedge clk) begin
		if (s1_valid_q)
			addr_o <= bin_sum[BIN_AW] ? '1 : bin_sum[BIN_AW-1:0]; // Overflow pins to all ones
	end

endmodule

//--- jh_ctrl_pkg.sv
package jh_ctrl_pkg;

	typedef enum logic [2:0] {
		ST_CLEAR,
		ST_COUNT,
		ST_DRAIN,
		ST_DUMP,
		ST_ACK
	} jh_state_e;

	// Table operation, shared by the sweep counter and the bin memory
	typedef enum logic [2:0] {
		OP_IDLE,
		OP_COUNT,
		OP_CLEAR,
		OP_DUMP,
		OP_DRAIN
	} jh_op_e;

	localparam int unsigned DRAIN_CYCLES = 4; // Covers the two address stages and the RMW

endpackage

//--- jh_cfg_pkg.sv
package jh_cfg_pkg;

	// ======================================================================
	// Histogram geometry
	// ======================================================================

	localparam int unsigned NUM_BINS = 200; // Two classes of 10 x 10 code pairs
	localparam int unsigned BIN_AW = 8;
	localparam int unsigned COUNT_W = 32;

	// ======================================================================
	// Sample fields and bin weights
	// ======================================================================

	localparam int unsigned CI_W = 1;
	localparam int unsigned CODE_W = 4;

	// Bin address is ci * CI_WEIGHT + ni * NI_WEIGHT + rd
	localparam int unsigned CI_WEIGHT = 100;
	localparam int unsigned NI_WEIGHT = 10;

endpackage
